// ==== rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes handled by the core, anything else runs as a no-op
    localparam logic [6:0] OPC_R    = 7'b0110011;
    localparam logic [6:0] OPC_I    = 7'b0010011;
    localparam logic [6:0] OPC_B    = 7'b1100011;
    localparam logic [6:0] OPC_S    = 7'b0100011;
    localparam logic [6:0] OPC_JAL  = 7'b1101111;
    localparam logic [6:0] OPC_HALT = 7'b0000000;

    localparam logic [2:0] F3_ADDSUB = 3'h0;
    localparam logic [2:0] F3_SLL    = 3'h1;
    localparam logic [2:0] F3_SLT    = 3'h2;
    localparam logic [2:0] F3_SLTU   = 3'h3;
    localparam logic [2:0] F3_XOR    = 3'h4;
    localparam logic [2:0] F3_SR     = 3'h5;
    localparam logic [2:0] F3_OR     = 3'h6;
    localparam logic [2:0] F3_AND    = 3'h7;

    // encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = {1'b0, F3_ADDSUB},
        ALU_SUB  = {1'b1, F3_ADDSUB},
        ALU_SLL  = {1'b0, F3_SLL},
        ALU_SLT  = {1'b0, F3_SLT},
        ALU_SLTU = {1'b0, F3_SLTU},
        ALU_XOR  = {1'b0, F3_XOR},
        ALU_SRL  = {1'b0, F3_SR},
        ALU_SRA  = {1'b1, F3_SR},
        ALU_OR   = {1'b0, F3_OR},
        ALU_AND  = {1'b0, F3_AND}
    } alu_op_t;

    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_BRANCH,
        CLS_STORE,
        CLS_JAL,
        CLS_HALT,
        CLS_NOP
    } instr_class_t;

    // values follow the branch funct3 field
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_cond_t;

    localparam word_t PC_STEP  = 32'd4;
    localparam word_t RESET_PC = 32'd0;

endpackage

// ==== rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
    input  rv_pkg::word_t        instr,
    output rv_pkg::instr_class_t instr_class,
    output rv_pkg::branch_cond_t branch_cond,
    output rv_pkg::alu_op_t      alu_op,
    output logic                 alu_src_imm,
    output rv_pkg::word_t        imm,
    output rv_pkg::reg_addr_t    rs1,
    output rv_pkg::reg_addr_t    rs2,
    output rv_pkg::reg_addr_t    rd
);

    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    logic       sub_flag;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    // branch funct3 lines up with the condition encoding
    assign branch_cond = branch_cond_t'(funct3);

    // funct7 bit 5 only matters for sub and sra, drop it elsewhere
    // so an odd encoding still lands on a legal ALU operation
    assign sub_flag = funct7_b5 && ((funct3 == F3_SR) ||
                      ((opcode == OPC_R) && (funct3 == F3_ADDSUB)));

    always_comb begin
        instr_class = CLS_NOP;
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b0;
        imm         = '0;
        case (opcode)
            OPC_R: begin
                instr_class = CLS_ALU;
                alu_op      = alu_op_t'({sub_flag, funct3});
            end
            OPC_I: begin
                instr_class = CLS_ALU;
                alu_op      = alu_op_t'({sub_flag, funct3});
                alu_src_imm = 1'b1;
                imm         = {{20{instr[31]}}, instr[31:20]};
            end
            OPC_B: begin
                instr_class = CLS_BRANCH;
                // eq and ne compare through subtraction, the rest through set-less-than
                case (funct3[2:1])
                    2'b10:   alu_op = ALU_SLT;
                    2'b11:   alu_op = ALU_SLTU;
                    default: alu_op = ALU_SUB;
                endcase
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OPC_S: begin
                instr_class = CLS_STORE;
                alu_src_imm = 1'b1;
                imm         = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OPC_JAL: begin
                instr_class = CLS_JAL;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            OPC_HALT: begin
                instr_class = CLS_HALT;
            end
            default: begin
                instr_class = CLS_NOP;
            end
        endcase
    end

endmodule

// ==== rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::alu_op_t alu_op,
    input  logic            alu_src_imm,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b_reg,
    input  rv_pkg::word_t   imm,
    output rv_pkg::word_t   result,
    output logic            zero
);

    import rv_pkg::*;

    word_t      b;
    logic [4:0] shamt;

    assign b     = alu_src_imm ? imm : b_reg;
    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'd0, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            // arithmetic shift keeps the sign bit
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

    // used by beq and bne after a subtraction
    assign zero = (result == '0);

endmodule

// ==== rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
    input  logic              Clock,
    input  logic              Reset_L,
    input  logic              write_en,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  rv_pkg::reg_addr_t rd,
    input  rv_pkg::word_t     write_data,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);

    import rv_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && (rd != '0)) begin
            regs[rd] <= write_data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== rv_sequencer.sv ====
`timescale 1ns/1ps

module rv_sequencer (
    input  logic                 Clock,
    input  logic                 Reset_L,
    input  rv_pkg::word_t        Instruction,
    input  logic                 DTAck,
    input  rv_pkg::instr_class_t instr_class,
    input  rv_pkg::branch_cond_t branch_cond,
    input  rv_pkg::word_t        imm,
    input  rv_pkg::word_t        alu_result,
    input  rv_pkg::word_t        rs2_data,
    input  logic                 zero,
    output rv_pkg::word_t        instr,
    output logic                 reg_write,
    output rv_pkg::word_t        write_data,
    output logic                 AS_L,
    output logic                 WE_L,
    output rv_pkg::word_t        Address,
    output rv_pkg::word_t        DataBus_Out,
    output logic                 Conduit
);

    import rv_pkg::*;

    typedef enum logic [2:0] {
        FETCH,
        EXECUTE,
        WRITE_BACK,
        STORE_WAIT,
        HALTED
    } state_t;

    state_t state;
    word_t  pc;
    word_t  pc_next;
    logic   branch_taken;

    assign pc_next = pc + PC_STEP;

    // slt and sltu leave the comparison in bit 0
    always_comb begin
        case (branch_cond)
            BR_EQ:   branch_taken = zero;
            BR_NE:   branch_taken = !zero;
            BR_LT:   branch_taken = alu_result[0];
            BR_GE:   branch_taken = !alu_result[0];
            BR_LTU:  branch_taken = alu_result[0];
            BR_GEU:  branch_taken = !alu_result[0];
            default: branch_taken = 1'b0;
        endcase
    end

    // jal links in execute, ALU ops write one cycle later
    assign reg_write  = (state == WRITE_BACK) ||
                        ((state == EXECUTE) && (instr_class == CLS_JAL));
    assign write_data = (instr_class == CLS_JAL) ? pc_next : alu_result;

    // operands stay put during the store wait, so the ALU sum holds the address
    assign Address     = (state == STORE_WAIT) ? alu_result : pc;
    assign DataBus_Out = (state == STORE_WAIT) ? rs2_data : '0;

    always_ff @(posedge Clock) begin
        if (state == FETCH) begin
            instr <= Instruction;
        end
    end

    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            state   <= FETCH;
            pc      <= RESET_PC;
            AS_L    <= 1'b1;
            WE_L    <= 1'b1;
            Conduit <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    state <= EXECUTE;
                end
                EXECUTE: begin
                    case (instr_class)
                        CLS_ALU: begin
                            state <= WRITE_BACK;
                        end
                        CLS_BRANCH: begin
                            pc    <= branch_taken ? pc + imm : pc_next;
                            state <= FETCH;
                        end
                        CLS_STORE: begin
                            AS_L  <= 1'b0;
                            WE_L  <= 1'b0;
                            state <= STORE_WAIT;
                        end
                        CLS_JAL: begin
                            pc    <= pc + imm;
                            state <= FETCH;
                        end
                        CLS_HALT: begin
                            // pc stays on the halt word
                            Conduit <= 1'b1;
                            state   <= HALTED;
                        end
                        default: begin
                            pc    <= pc_next;
                            state <= FETCH;
                        end
                    endcase
                end
                WRITE_BACK: begin
                    pc    <= pc_next;
                    state <= FETCH;
                end
                STORE_WAIT: begin
                    // no timeout, the core waits as long as DTAck stays low
                    if (DTAck) begin
                        AS_L  <= 1'b1;
                        WE_L  <= 1'b1;
                        pc    <= pc_next;
                        state <= FETCH;
                    end
                end
                HALTED: begin
                    state <= HALTED;
                end
                default: begin
                    state <= FETCH;
                end
            endcase
        end
    end

endmodule

// ==== rv_cpu.sv ====
`timescale 1ns/1ps

module rv_cpu (
    input  logic          Clock,
    input  logic          Reset_L,
    input  rv_pkg::word_t Instruction,
    // loads are not implemented, the read bus is left unconnected
    input  rv_pkg::word_t DataBus_In,
    input  logic          DTAck,
    output logic          AS_L,
    output logic          WE_L,
    output rv_pkg::word_t Address,
    output rv_pkg::word_t DataBus_Out,
    output logic          Conduit
);

    import rv_pkg::*;

    word_t        instr;
    instr_class_t instr_class;
    branch_cond_t branch_cond;
    alu_op_t      alu_op;
    logic         alu_src_imm;
    word_t        imm;
    reg_addr_t    rs1;
    reg_addr_t    rs2;
    reg_addr_t    rd;
    word_t        rs1_data;
    word_t        rs2_data;
    word_t        alu_result;
    logic         zero;
    logic         reg_write;
    word_t        write_data;

    rv_decode i_decode (
        .instr       (instr),
        .instr_class (instr_class),
        .branch_cond (branch_cond),
        .alu_op      (alu_op),
        .alu_src_imm (alu_src_imm),
        .imm         (imm),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd)
    );

    rv_regfile i_regfile (
        .Clock      (Clock),
        .Reset_L    (Reset_L),
        .write_en   (reg_write),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .write_data (write_data),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    rv_alu i_alu (
        .alu_op      (alu_op),
        .alu_src_imm (alu_src_imm),
        .a           (rs1_data),
        .b_reg       (rs2_data),
        .imm         (imm),
        .result      (alu_result),
        .zero        (zero)
    );

    rv_sequencer i_sequencer (
        .Clock       (Clock),
        .Reset_L     (Reset_L),
        .Instruction (Instruction),
        .DTAck       (DTAck),
        .instr_class (instr_class),
        .branch_cond (branch_cond),
        .imm         (imm),
        .alu_result  (alu_result),
        .rs2_data    (rs2_data),
        .zero        (zero),
        .instr       (instr),
        .reg_write   (reg_write),
        .write_data  (write_data),
        .AS_L        (AS_L),
        .WE_L        (WE_L),
        .Address     (Address),
        .DataBus_Out (DataBus_Out),
        .Conduit     (Conduit)
    );

endmodule

// ==== rv_cpu_props.sv ====
`timescale 1ns/1ps

module rv_cpu_props (
    input logic          Clock,
    input logic          Reset_L,
    input logic          DTAck,
    input logic          AS_L,
    input logic          WE_L,
    input rv_pkg::word_t Address,
    input rv_pkg::word_t DataBus_Out,
    input logic          Conduit
);

    import rv_pkg::*;

    // one cycle of reset is enough to settle the bus outputs
    reset_idle: assert property (@(posedge Clock)
        !Reset_L |=> (AS_L && WE_L && !Conduit && (Address == RESET_PC)))
        else $error("bus outputs not idle after reset");

    write_needs_strobe: assert property (@(posedge Clock) disable iff (!Reset_L)
        !WE_L |-> !AS_L)
        else $error("WE_L low without AS_L");

    store_stable: assert property (@(posedge Clock) disable iff (!Reset_L)
        (!AS_L && !DTAck) |=> ($stable(Address) && $stable(DataBus_Out)))
        else $error("store address or data moved before DTAck");

    store_aligned: assert property (@(posedge Clock) disable iff (!Reset_L)
        !AS_L |-> (Address[1:0] == 2'b00))
        else $error("store address not word aligned");

    strobe_release: assert property (@(posedge Clock) disable iff (!Reset_L)
        (!AS_L && DTAck) |=> AS_L)
        else $error("AS_L did not rise after DTAck");

    halt_sticky: assert property (@(posedge Clock) disable iff (!Reset_L)
        Conduit |=> (Conduit && AS_L && WE_L))
        else $error("Conduit dropped or bus active after halt");

endmodule

bind rv_cpu rv_cpu_props i_props (
    .Clock       (Clock),
    .Reset_L     (Reset_L),
    .DTAck       (DTAck),
    .AS_L        (AS_L),
    .WE_L        (WE_L),
    .Address     (Address),
    .DataBus_Out (DataBus_Out),
    .Conduit     (Conduit)
);

// ==== tb_rv_cpu.sv ====
`timescale 1ns/1ps

module tb_rv_cpu;

    import rv_pkg::*;

    localparam int    IMEM_WORDS = 128;
    localparam int    WAIT_LIMIT = 200;
    localparam word_t STORE_BASE = 32'h0000_0400;
    localparam word_t MARKER     = 32'h0000_05A5;
    localparam logic [31:0] RNG_SEED = 32'h4fdf_6fa6;

    logic  Clock = 1'b0;
    logic  Reset_L;
    word_t Instruction;
    word_t DataBus_In;
    logic  DTAck;
    logic  AS_L;
    logic  WE_L;
    word_t Address;
    word_t DataBus_Out;
    logic  Conduit;

    word_t imem [0:IMEM_WORDS-1];
    int    pc_idx;
    int    slot;
    string exp_name [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t log_addr [$];
    word_t log_data [$];

    rv_cpu i_dut (
        .Clock       (Clock),
        .Reset_L     (Reset_L),
        .Instruction (Instruction),
        .DataBus_In  (DataBus_In),
        .DTAck       (DTAck),
        .AS_L        (AS_L),
        .WE_L        (WE_L),
        .Address     (Address),
        .DataBus_Out (DataBus_Out),
        .Conduit     (Conduit)
    );

    always #10 Clock = ~Clock;

    // instruction port answers from the word at Address / 4
    assign Instruction = imem[Address[8:2]];

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t r_type(logic f7b5, logic [2:0] f3, reg_addr_t rd,
                                     reg_addr_t rs1, reg_addr_t rs2);
        return {1'b0, f7b5, 5'b00000, rs2, rs1, f3, rd, OPC_R};
    endfunction

    function automatic word_t i_type(logic [2:0] f3, reg_addr_t rd, reg_addr_t rs1,
                                     logic [11:0] imm);
        return {imm, rs1, f3, rd, OPC_I};
    endfunction

    // sw with x0 as the base register
    function automatic word_t store_word(reg_addr_t rs2, logic [11:0] offset);
        return {offset[11:5], rs2, 5'd0, 3'b010, offset[4:0], OPC_S};
    endfunction

    function automatic word_t branch_word(branch_cond_t cond, reg_addr_t rs1, reg_addr_t rs2,
                                          logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, cond, off[4:1], off[11], OPC_B};
    endfunction

    function automatic word_t jal_word(reg_addr_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic abort_run(string reason);
        $display("STATUS: FAIL");
        $fatal(1, reason);
    endtask

    task automatic check_word(string name, word_t expected, word_t actual);
        assert (actual === expected) else begin
            $display("** Error %s: expected %08h, actual %08h", name, expected, actual);
            abort_run("store log does not match the expected sequence");
        end
    endtask

    task automatic emit(word_t w);
        imem[7'(pc_idx)] = w;
        pc_idx++;
    endtask

    // every store gets its own slot, so a skipped marker still moves the address on
    task automatic store_and_expect(string name, reg_addr_t rs2, word_t expected, bit expect_it);
        word_t addr;
        addr = STORE_BASE + 32'(slot * 4);
        emit(store_word(rs2, addr[11:0]));
        slot++;
        if (expect_it) begin
            exp_name.push_back(name);
            exp_addr.push_back(addr);
            exp_data.push_back(expected);
        end
    endtask

    task automatic alu_and_store(string name, word_t instr, reg_addr_t rd, word_t expected);
        emit(instr);
        store_and_expect(name, rd, expected, 1'b1);
    endtask

    // a taken branch jumps over the marker store
    task automatic branch_case(string name, branch_cond_t cond, reg_addr_t rs1, reg_addr_t rs2,
                               bit taken);
        emit(branch_word(cond, rs1, rs2, 13'd8));
        store_and_expect(name, 5'd15, MARKER, !taken);
    endtask

    task automatic load_program();
        word_t link;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[7'(i)] = i_type(F3_ADDSUB, 5'd0, 5'd0, 12'(i));
        end
        pc_idx = 0;
        slot   = 0;
        // x1 = 7, x2 = -3
        alu_and_store("addi", i_type(F3_ADDSUB, 5'd1, 5'd0, 12'd7), 5'd1, 32'd7);
        alu_and_store("addi neg", i_type(F3_ADDSUB, 5'd2, 5'd0, 12'hFFD), 5'd2, 32'hFFFF_FFFD);
        alu_and_store("add", r_type(1'b0, F3_ADDSUB, 5'd3, 5'd1, 5'd2), 5'd3, 32'd4);
        alu_and_store("sub", r_type(1'b1, F3_ADDSUB, 5'd4, 5'd1, 5'd2), 5'd4, 32'd10);
        alu_and_store("slt", r_type(1'b0, F3_SLT, 5'd5, 5'd2, 5'd1), 5'd5, 32'd1);
        alu_and_store("sltu", r_type(1'b0, F3_SLTU, 5'd6, 5'd2, 5'd1), 5'd6, 32'd0);
        alu_and_store("xor", r_type(1'b0, F3_XOR, 5'd7, 5'd1, 5'd2), 5'd7, 32'hFFFF_FFFA);
        alu_and_store("or", r_type(1'b0, F3_OR, 5'd8, 5'd1, 5'd2), 5'd8, 32'hFFFF_FFFF);
        alu_and_store("and", r_type(1'b0, F3_AND, 5'd9, 5'd1, 5'd2), 5'd9, 32'd5);
        alu_and_store("sll", r_type(1'b0, F3_SLL, 5'd10, 5'd1, 5'd1), 5'd10, 32'h0000_0380);
        alu_and_store("srl", r_type(1'b0, F3_SR, 5'd11, 5'd2, 5'd1), 5'd11, 32'h01FF_FFFF);
        alu_and_store("sra", r_type(1'b1, F3_SR, 5'd12, 5'd2, 5'd1), 5'd12, 32'hFFFF_FFFF);
        alu_and_store("xori", i_type(F3_XOR, 5'd13, 5'd2, 12'h0F0), 5'd13, 32'hFFFF_FF0D);
        alu_and_store("srai", i_type(F3_SR, 5'd14, 5'd2, 12'h401), 5'd14, 32'hFFFF_FFFE);
        alu_and_store("x0 write", i_type(F3_ADDSUB, 5'd0, 5'd1, 12'd5), 5'd0, 32'd0);
        emit(i_type(F3_ADDSUB, 5'd15, 5'd0, MARKER[11:0]));
        branch_case("beq taken", BR_EQ, 5'd1, 5'd1, 1'b1);
        branch_case("beq not taken", BR_EQ, 5'd1, 5'd2, 1'b0);
        branch_case("bne taken", BR_NE, 5'd1, 5'd2, 1'b1);
        branch_case("bne not taken", BR_NE, 5'd1, 5'd1, 1'b0);
        branch_case("blt taken", BR_LT, 5'd2, 5'd1, 1'b1);
        branch_case("blt not taken", BR_LT, 5'd1, 5'd2, 1'b0);
        branch_case("bge taken", BR_GE, 5'd1, 5'd2, 1'b1);
        branch_case("bge not taken", BR_GE, 5'd2, 5'd1, 1'b0);
        branch_case("bltu taken", BR_LTU, 5'd1, 5'd2, 1'b1);
        branch_case("bltu not taken", BR_LTU, 5'd2, 5'd1, 1'b0);
        branch_case("bgeu taken", BR_GEU, 5'd2, 5'd1, 1'b1);
        branch_case("bgeu not taken", BR_GEU, 5'd1, 5'd2, 1'b0);
        // jal over one marker store, the target stores the link register
        link = 32'(pc_idx * 4) + 32'd4;
        emit(jal_word(5'd13, 21'd8));
        store_and_expect("jal skipped", 5'd15, MARKER, 1'b0);
        store_and_expect("jal link", 5'd13, link, 1'b1);
        emit(32'h0000_0000);
    endtask

    task automatic wait_for_store(int index);
        int cycles;
        cycles = 0;
        while (log_addr.size() <= index) begin
            @(negedge Clock);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run("timed out waiting for the next store");
            end
        end
    endtask

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        while (!Conduit) begin
            @(negedge Clock);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run("timed out waiting for Conduit after the halt word");
            end
        end
    endtask

    // bus responder, acks each store after a random delay
    initial begin
        logic [31:0] rng;
        logic [2:0]  ack_wait;
        logic        ack_armed;
        rng       = RNG_SEED;
        ack_wait  = 3'd0;
        ack_armed = 1'b0;
        DTAck     = 1'b0;
        forever begin
            @(negedge Clock);
            if (DTAck) begin
                DTAck = 1'b0;
            end else if (Reset_L && !AS_L) begin
                // every bus cycle of this core is a write
                assert (!WE_L) else begin
                    abort_run("WE_L is high while a store holds AS_L low");
                end
                if (!ack_armed) begin
                    rng       = xorshift(rng);
                    ack_wait  = 3'(rng % 32'd6);
                    ack_armed = 1'b1;
                end
                if (ack_wait == 3'd0) begin
                    log_addr.push_back(Address);
                    log_data.push_back(DataBus_Out);
                    ack_armed = 1'b0;
                    DTAck     = 1'b1;
                end else begin
                    ack_wait = ack_wait - 3'd1;
                end
            end
        end
    end

    initial begin
        Reset_L    = 1'b0;
        DataBus_In = '0;
        load_program();
        repeat (16) @(negedge Clock);
        assert (AS_L && WE_L && !Conduit) else begin
            abort_run("strobes or Conduit not idle during reset");
        end
        check_word("reset Address", RESET_PC, Address);
        Reset_L = 1'b1;
        for (int k = 0; k < exp_addr.size(); k++) begin
            wait_for_store(k);
            check_word({exp_name[k], " address"}, exp_addr[k], log_addr[k]);
            check_word({exp_name[k], " data"}, exp_data[k], log_data[k]);
        end
        wait_for_halt();
        // the core must stay quiet once halted
        repeat (20) @(negedge Clock);
        if (log_addr.size() == exp_addr.size()) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run("a store was seen after the halt or beyond the expected sequence");
        end
    end

endmodule

// ==== sources.f ====
rv_pkg.sv
rv_decode.sv
rv_alu.sv
rv_regfile.sv
rv_sequencer.sv
rv_cpu.sv
rv_cpu_props.sv
tb_rv_cpu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rv_cpu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_rv_cpu \
    -f sources.f \
    -o sim_rv_cpu

./obj_dir/sim_rv_cpu
